// ==== common/prom_pkg.sv ====
package prom_pkg;

    // M25P16 command bytes
    localparam logic [7:0] OP_WREN  = 8'h06;    // write enable
    localparam logic [7:0] OP_WRDI  = 8'h04;    // write disable
    localparam logic [7:0] OP_RDID  = 8'h9F;    // read id, 3 bytes used
    localparam logic [7:0] OP_RDSR  = 8'h05;    // read status reg
    localparam logic [7:0] OP_WRSR  = 8'h01;    // write status reg
    localparam logic [7:0] OP_READ  = 8'h03;    // read data, 4 bytes
    localparam logic [7:0] OP_FREAD = 8'h0B;    // fast read, dummy byte
    localparam logic [7:0] OP_PP    = 8'h02;    // page program, block write only
    localparam logic [7:0] OP_SE    = 8'hD8;    // sector erase
    localparam logic [7:0] OP_BE    = 8'hC7;    // bulk erase
    localparam logic [7:0] OP_DP    = 8'hB9;    // deep power down
    localparam logic [7:0] OP_RES   = 8'hAB;    // release, old style id
    localparam logic [7:0] OP_NOP   = 8'h00;    // no operation

    localparam int QUAD_W     = 32;             // host quadlet
    localparam int BLK_ADDR_W = 6;              // block quadlet address
    localparam int BLK_CNT_W  = 9;              // block quadlet counter
    localparam int FIFO_DEPTH = 16;             // buffered operations
    localparam int BIT_CNT_W  = 7;              // half-period counters

    // half-period counts minus one, per bit length
    localparam logic [BIT_CNT_W-1:0] HALF_NONE = 7'd0;
    localparam logic [BIT_CNT_W-1:0] HALF_8    = 7'd15;
    localparam logic [BIT_CNT_W-1:0] HALF_16   = 7'd31;
    localparam logic [BIT_CNT_W-1:0] HALF_24   = 7'd47;
    localparam logic [BIT_CNT_W-1:0] HALF_32   = 7'd63;
    localparam logic [BIT_CNT_W-1:0] HALF_40   = 7'd79;

    localparam logic [7:0] ERR_TAG = 8'h01;     // top byte of abort result

    // engine states, also shown in status
    localparam logic [2:0] ST_IDLE     = 3'd0;
    localparam logic [2:0] ST_SELECT   = 3'd1;
    localparam logic [2:0] ST_WRITE    = 3'd2;
    localparam logic [2:0] ST_READ     = 3'd3;
    localparam logic [2:0] ST_DESELECT = 3'd4;

    typedef enum logic [1:0] {
        KIND_SINGLE,                            // one cs frame
        KIND_BLK_OPEN,                          // pp header, cs stays low
        KIND_BLK_DATA,                          // one page quadlet
        KIND_BLK_CLOSE                          // raise cs, data[31] = abort
    } op_kind_t;

    typedef struct packed {
        op_kind_t               kind;
        logic [QUAD_W-1:0]      data;           // msb first on mosi
        logic [BIT_CNT_W-1:0]   send_half;      // halves to send - 1
        logic [BIT_CNT_W-1:0]   recv_half;      // halves to receive - 1, 0 if none
    } prom_op_t;

    typedef struct packed {
        logic [21:0] zero;
        logic        overflow;                  // sticky fifo overflow
        logic        busy;                      // engine or fifo not drained
        logic        cs;
        logic        sclk;
        logic        miso;
        logic        mosi;
        logic        blk_wrt;                   // block write open in decoder
        logic [2:0]  state;                     // engine state
    } prom_status_t;

endpackage

// ==== rtl/op_fifo.sv ====
`timescale 1ns/1ps

module op_fifo #(
    parameter type item_t = prom_pkg::prom_op_t,
    parameter int  DEPTH  = prom_pkg::FIFO_DEPTH
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  push,
    input  item_t push_item,
    input  logic  pop,
    output item_t head,
    output logic  empty,
    output logic  overflow
);

    item_t                      mem [DEPTH];    // no reset on storage
    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;          // occupancy
    logic                       full;
    logic                       do_wr;
    logic                       do_rd;

    assign empty = (count == '0);
    assign full  = (count == DEPTH);
    assign head  = mem[rd_ptr];                 // show-ahead
    assign do_rd = pop && !empty;
    assign do_wr = push && (!full || do_rd);    // a pop frees a slot this cycle

    always_ff @(posedge clk) begin
        if (do_wr)
            mem[wr_ptr] <= push_item;
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_wr)
                wr_ptr <= (wr_ptr == DEPTH-1) ? '0 : wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= (rd_ptr == DEPTH-1) ? '0 : rd_ptr + 1'b1;
            if (do_wr && !do_rd)
                count <= count + 1'b1;
            else if (do_rd && !do_wr)
                count <= count - 1'b1;
            if (push && !do_wr)
                overflow <= 1'b1;               // dropped, sticky
        end
    end

endmodule

// ==== prom_ctrl/prom_cmd_decode.sv ====
`timescale 1ns/1ps

module prom_cmd_decode (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [prom_pkg::QUAD_W-1:0]      prom_cmd,
    input  logic                             prom_reg_wen,
    input  logic                             prom_blk_start,
    input  logic                             prom_blk_wen,
    input  logic [prom_pkg::BLK_ADDR_W-1:0]  prom_blk_addr,
    input  logic                             prom_blk_end,
    output logic                             push,
    output prom_pkg::prom_op_t               push_op,
    output logic                             err_strobe,
    output logic [prom_pkg::QUAD_W-1:0]      err_word,
    output logic                             blk_wrt
);
    import prom_pkg::*;

    logic [BLK_CNT_W-1:0] next_blk_addr;        // expected quadlet number
    logic [BIT_CNT_W-1:0] send_half;
    logic [BIT_CNT_W-1:0] recv_half;
    logic                 known;                // opcode is in the table
    logic                 in_seq;

    // opcode -> frame length
    always_comb begin
        known     = 1'b1;
        send_half = HALF_8;                     // most commands are one byte
        recv_half = HALF_NONE;
        case (prom_cmd[31:24])
            OP_WREN, OP_WRDI, OP_BE, OP_DP: begin
            end
            OP_RDID: recv_half = HALF_24;       // mfr, type, capacity
            OP_RDSR: recv_half = HALF_8;
            OP_WRSR: send_half = HALF_16;       // opcode + status byte
            OP_READ: begin
                send_half = HALF_32;            // opcode + 24b addr
                recv_half = HALF_32;
            end
            OP_FREAD: begin
                send_half = HALF_40;            // plus dummy byte of zeros
                recv_half = HALF_32;
            end
            OP_SE:   send_half = HALF_32;
            OP_RES: begin
                send_half = HALF_32;            // 3 dummy bytes
                recv_half = HALF_8;             // electronic signature
            end
            OP_NOP:  known = 1'b0;              // nothing to do
            default: known = 1'b0;              // incl. pp as quadlet write
        endcase
    end

    assign in_seq = (prom_blk_addr == next_blk_addr[BLK_ADDR_W-1:0]);

    // abort word: tag, expected count, received addr
    assign err_word = {ERR_TAG, 7'h00, next_blk_addr, 2'b00, prom_blk_addr};

    always_comb begin
        push              = 1'b0;
        err_strobe        = 1'b0;
        push_op.kind      = KIND_SINGLE;
        push_op.data      = prom_cmd;
        push_op.send_half = send_half;
        push_op.recv_half = recv_half;
        if (prom_reg_wen && !blk_wrt) begin     // register cmds wait for block end
            push = known;
        end else if (prom_blk_start && !blk_wrt) begin
            push              = 1'b1;
            push_op.kind      = KIND_BLK_OPEN;
            push_op.data      = {OP_PP, prom_cmd[23:0]};
            push_op.send_half = HALF_32;
            push_op.recv_half = HALF_NONE;
        end else if (prom_blk_wen && blk_wrt) begin
            push              = 1'b1;
            push_op.send_half = HALF_32;        // one quadlet
            push_op.recv_half = HALF_NONE;
            if (in_seq) begin
                push_op.kind = KIND_BLK_DATA;
            end else begin
                push_op.kind = KIND_BLK_CLOSE;  // missed one, abort
                push_op.data = {1'b1, {(QUAD_W-1){1'b0}}};
                err_strobe   = 1'b1;
            end
        end else if (prom_blk_end && blk_wrt) begin
            push              = 1'b1;
            push_op.kind      = KIND_BLK_CLOSE;
            push_op.data      = '0;             // normal close
            push_op.send_half = HALF_NONE;
            push_op.recv_half = HALF_NONE;
        end
    end

    // block write tracking
    always_ff @(posedge clk) begin
        if (!reset) begin
            blk_wrt       <= 1'b0;
            next_blk_addr <= '0;
        end else if (prom_blk_start && !blk_wrt && !prom_reg_wen) begin
            blk_wrt       <= 1'b1;
            next_blk_addr <= '0;
        end else if (prom_blk_wen && blk_wrt) begin
            if (in_seq)
                next_blk_addr <= next_blk_addr + 1'b1;
            else
                blk_wrt <= 1'b0;                // aborted
        end else if (prom_blk_end) begin
            blk_wrt <= 1'b0;
        end
    end

endmodule

// ==== prom_ctrl/prom_spi_engine.sv ====
`timescale 1ns/1ps

module prom_spi_engine (
    input  logic                         clk,
    input  logic                         reset,
    input  prom_pkg::prom_op_t           head,
    input  logic                         empty,
    input  logic                         err_strobe,
    input  logic [prom_pkg::QUAD_W-1:0]  err_word,
    input  logic                         prom_miso,
    output logic                         pop,
    output logic                         prom_cs,
    output logic                         prom_sclk,
    output logic                         prom_mosi,
    output logic [prom_pkg::QUAD_W-1:0]  prom_result,
    output logic                         busy,
    output logic [2:0]                   state
);
    import prom_pkg::*;

    logic [BIT_CNT_W-1:0] seqn;                 // half-period counter, bit 0 is sclk
    logic [BIT_CNT_W-1:0] send_half;
    logic [BIT_CNT_W-1:0] recv_half;
    op_kind_t             kind;                 // kind of current op
    logic [QUAD_W-1:0]    shift_out;            // mosi shifter
    logic                 blk_open;             // cs held low across entries
    logic [BLK_CNT_W-1:0] blk_cnt;              // quadlets programmed
    logic [QUAD_W-1:0]    err_hold;             // abort word, waits for close

    assign pop       = (state == ST_IDLE) && !empty;
    assign busy      = (state != ST_IDLE);
    assign prom_sclk = seqn[0];
    assign prom_mosi = shift_out[QUAD_W-1];

    // error word arrives with the host write, close is popped later
    always_ff @(posedge clk) begin
        if (err_strobe)
            err_hold <= err_word;
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            state       <= ST_IDLE;
            prom_cs     <= 1'b1;
            seqn        <= '0;
            shift_out   <= '0;
            blk_open    <= 1'b0;
            blk_cnt     <= '0;
            prom_result <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (pop) begin
                        shift_out <= head.data;
                        send_half <= head.send_half;
                        recv_half <= head.recv_half;
                        kind      <= head.kind;
                        seqn      <= '0;
                        case (head.kind)
                            KIND_SINGLE: begin
                                prom_cs <= 1'b0;
                                state   <= ST_SELECT;
                            end
                            KIND_BLK_OPEN: begin
                                if (!blk_open) begin        // ignore double open
                                    prom_cs  <= 1'b0;
                                    blk_open <= 1'b1;
                                    blk_cnt  <= '0;
                                    state    <= ST_SELECT;
                                end
                            end
                            KIND_BLK_DATA: begin
                                if (blk_open)               // header lost -> drop
                                    state <= ST_WRITE;      // cs already low
                            end
                            KIND_BLK_CLOSE: begin
                                if (blk_open) begin
                                    blk_open <= 1'b0;
                                    prom_cs  <= 1'b1;       // starts the program cycle
                                    if (head.data[QUAD_W-1])
                                        prom_result <= err_hold;
                                    else
                                        prom_result <= {{(QUAD_W-BLK_CNT_W){1'b0}}, blk_cnt};
                                    state <= ST_DESELECT;
                                end
                            end
                            default: state <= ST_IDLE;
                        endcase
                    end
                end

                ST_SELECT: begin                // cs setup, sclk low
                    prom_result <= '0;
                    state       <= ST_WRITE;
                end

                ST_WRITE: begin
                    if (seqn[0])                // falling sclk, next bit
                        shift_out <= {shift_out[QUAD_W-2:0], 1'b0};
                    if (seqn == send_half) begin
                        seqn <= '0;
                        if (kind == KIND_BLK_DATA) begin
                            blk_cnt <= blk_cnt + 1'b1;
                            state   <= ST_IDLE;     // keep cs low for next quadlet
                        end else if (kind == KIND_BLK_OPEN) begin
                            state <= ST_IDLE;
                        end else if (recv_half == HALF_NONE) begin
                            prom_cs <= 1'b1;
                            state   <= ST_DESELECT;
                        end else begin
                            state <= ST_READ;
                        end
                    end else begin
                        seqn <= seqn + 1'b1;
                    end
                end

                ST_READ: begin
                    if (!seqn[0])               // rising sclk, sample
                        prom_result <= {prom_result[QUAD_W-2:0], prom_miso};
                    if (seqn == recv_half) begin
                        seqn    <= '0;
                        prom_cs <= 1'b1;
                        state   <= ST_DESELECT;
                    end else begin
                        seqn <= seqn + 1'b1;
                    end
                end

                ST_DESELECT: begin              // one cycle with cs high
                    state <= ST_IDLE;
                end

                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// ==== rtl/prom_if_top.sv ====
`timescale 1ns/1ps

module prom_if_top (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [prom_pkg::QUAD_W-1:0]      prom_cmd,
    input  logic                             prom_reg_wen,
    input  logic                             prom_blk_start,
    input  logic                             prom_blk_wen,
    input  logic [prom_pkg::BLK_ADDR_W-1:0]  prom_blk_addr,
    input  logic                             prom_blk_end,
    output logic                             prom_mosi,
    input  logic                             prom_miso,
    output logic                             prom_sclk,
    output logic                             prom_cs,
    output logic [prom_pkg::QUAD_W-1:0]      prom_result,
    output prom_pkg::prom_status_t           prom_status
);
    import prom_pkg::*;

    logic              push;
    prom_op_t          push_op;
    logic              pop;
    prom_op_t          head;
    logic              empty;
    logic              overflow;
    logic              err_strobe;
    logic [QUAD_W-1:0] err_word;
    logic              blk_wrt;
    logic              eng_busy;
    logic [2:0]        eng_state;

    prom_cmd_decode decode0 (
        .clk            (clk),
        .reset          (reset),
        .prom_cmd       (prom_cmd),
        .prom_reg_wen   (prom_reg_wen),
        .prom_blk_start (prom_blk_start),
        .prom_blk_wen   (prom_blk_wen),
        .prom_blk_addr  (prom_blk_addr),
        .prom_blk_end   (prom_blk_end),
        .push           (push),
        .push_op        (push_op),
        .err_strobe     (err_strobe),
        .err_word       (err_word),
        .blk_wrt        (blk_wrt)
    );

    op_fifo #(.item_t(prom_op_t), .DEPTH(FIFO_DEPTH)) fifo0 (
        .clk       (clk),
        .reset     (reset),
        .push      (push),
        .push_item (push_op),
        .pop       (pop),
        .head      (head),
        .empty     (empty),
        .overflow  (overflow)
    );

    prom_spi_engine engine0 (
        .clk         (clk),
        .reset       (reset),
        .head        (head),
        .empty       (empty),
        .err_strobe  (err_strobe),
        .err_word    (err_word),
        .prom_miso   (prom_miso),
        .pop         (pop),
        .prom_cs     (prom_cs),
        .prom_sclk   (prom_sclk),
        .prom_mosi   (prom_mosi),
        .prom_result (prom_result),
        .busy        (eng_busy),
        .state       (eng_state)
    );

    always_comb begin
        prom_status          = '0;
        prom_status.overflow = overflow;
        prom_status.busy     = eng_busy || !empty; // low only when fully drained
        prom_status.cs       = prom_cs;
        prom_status.sclk     = prom_sclk;
        prom_status.miso     = prom_miso;
        prom_status.mosi     = prom_mosi;
        prom_status.blk_wrt  = blk_wrt;
        prom_status.state    = eng_state;
    end

endmodule

// ==== bench/m25p16_model.sv ====
`timescale 1ns/1ps

module m25p16_model (
    input  logic cs,
    input  logic sclk,
    input  logic mosi,
    output logic miso
);
    import prom_pkg::*;

    logic [7:0]  mem [256];                     // one page, address wraps
    logic [39:0] in_shift  = '0;                // last bits seen on mosi
    logic [31:0] out_shift = '0;                // reply, msb first
    logic [7:0]  opcode    = OP_NOP;
    logic [7:0]  page_addr = '0;                // next byte to program
    logic        wel       = 1'b0;              // status bit 1
    logic        dp        = 1'b0;              // deep power down
    logic        out_en    = 1'b0;              // reply phase running
    int          bit_cnt   = 0;                 // bits in this cs frame
    int          i;

    initial begin
        miso = 1'b0;
        for (i = 0; i < 256; i++)
            mem[i] = i[7:0] ^ 8'hC3;            // pattern follows address
    end

    function automatic logic [31:0] read_quad(input logic [7:0] a);
        logic [7:0] a1;
        logic [7:0] a2;
        logic [7:0] a3;
        a1 = a + 8'd1;
        a2 = a + 8'd2;
        a3 = a + 8'd3;
        return {mem[a], mem[a1], mem[a2], mem[a3]};
    endfunction

    task automatic start_reply(input logic [31:0] word);
        out_shift = word;                       // first bit on next falling sclk
        out_en    = 1'b1;
    endtask

    always @(posedge sclk or negedge sclk or posedge cs) begin
        if (cs === 1'b1) begin                  // end of frame
            if (bit_cnt == 8) begin
                case (opcode)
                    OP_WREN: wel = 1'b1;
                    OP_WRDI: wel = 1'b0;
                    OP_DP:   dp  = 1'b1;
                    default: ;
                endcase
            end
            if (opcode == OP_RES && bit_cnt >= 8)
                dp = 1'b0;                      // woken up
            if (opcode == OP_PP && bit_cnt >= 32)
                wel = 1'b0;                     // program done, no busy time
            bit_cnt = 0;
            out_en  = 1'b0;
            opcode  = OP_NOP;
        end else if (cs === 1'b0 && sclk === 1'b1) begin
            in_shift = {in_shift[38:0], mosi};  // rising sclk, take mosi
            bit_cnt  = bit_cnt + 1;
            if (bit_cnt == 8)
                opcode = in_shift[7:0];
            if (!dp || opcode == OP_RES) begin  // only release works in dp
                case (opcode)
                    OP_RDID:
                        if (bit_cnt == 8)
                            start_reply({24'h202015, 8'h00});   // mfr, type, size
                    OP_RDSR:
                        if (bit_cnt == 8)
                            start_reply({6'b0, wel, 1'b0, 24'h0});
                    OP_RES:
                        if (bit_cnt == 32)
                            start_reply({8'h14, 24'h0});        // after 3 dummies
                    OP_READ:
                        if (bit_cnt == 32) begin
                            page_addr = in_shift[7:0];
                            start_reply(read_quad(page_addr));
                        end
                    OP_FREAD:
                        if (bit_cnt == 40) begin
                            page_addr = in_shift[15:8];         // dummy byte last
                            start_reply(read_quad(page_addr));
                        end
                    OP_PP: begin
                        if (bit_cnt == 32)
                            page_addr = in_shift[7:0];
                        else if (bit_cnt > 32 && bit_cnt % 8 == 0 && wel) begin
                            mem[page_addr] = in_shift[7:0];
                            page_addr      = page_addr + 8'd1;  // wraps in page
                        end
                    end
                    default: ;
                endcase
            end
        end else if (cs === 1'b0 && sclk === 1'b0 && out_en) begin
            miso      = out_shift[31];          // falling sclk, next bit
            out_shift = {out_shift[30:0], 1'b0};
        end
    end

endmodule

// ==== bench/tb_prom.sv ====
`timescale 1ns/1ps

module tb_prom;
    import prom_pkg::*;

    localparam int IDLE_LIMIT = 2000;           // cycles to drain a full fifo of quadlets

    logic                  clk;
    logic                  reset;
    logic [QUAD_W-1:0]     prom_cmd;
    logic                  prom_reg_wen;
    logic                  prom_blk_start;
    logic                  prom_blk_wen;
    logic [BLK_ADDR_W-1:0] prom_blk_addr;
    logic                  prom_blk_end;
    logic                  prom_mosi;
    logic                  prom_miso;
    logic                  prom_sclk;
    logic                  prom_cs;
    logic [QUAD_W-1:0]     prom_result;
    prom_status_t          prom_status;

    int                    seed;
    int                    test_errors;         // failures in the running test
    int                    pass_count;
    int                    fail_count;
    logic [QUAD_W-1:0]     page [8];            // quadlets of the block test
    logic [QUAD_W-1:0]     abort_word;

    prom_if_top dut0 (
        .clk            (clk),
        .reset          (reset),
        .prom_cmd       (prom_cmd),
        .prom_reg_wen   (prom_reg_wen),
        .prom_blk_start (prom_blk_start),
        .prom_blk_wen   (prom_blk_wen),
        .prom_blk_addr  (prom_blk_addr),
        .prom_blk_end   (prom_blk_end),
        .prom_mosi      (prom_mosi),
        .prom_miso      (prom_miso),
        .prom_sclk      (prom_sclk),
        .prom_cs        (prom_cs),
        .prom_result    (prom_result),
        .prom_status    (prom_status)
    );

    m25p16_model flash0 (
        .cs   (prom_cs),
        .sclk (prom_sclk),
        .mosi (prom_mosi),
        .miso (prom_miso)
    );

    always #4 clk = ~clk;                       // 8 ns period

    task automatic clear_host();
        prom_reg_wen   = 1'b0;
        prom_blk_start = 1'b0;
        prom_blk_wen   = 1'b0;
        prom_blk_end   = 1'b0;
    endtask

    // each strobe lasts until the next call or wait
    task automatic reg_write(input logic [QUAD_W-1:0] cmd);
        @(posedge clk);
        #1;
        clear_host();
        prom_cmd     = cmd;
        prom_reg_wen = 1'b1;
    endtask

    task automatic blk_open(input logic [23:0] addr);
        @(posedge clk);
        #1;
        clear_host();
        prom_cmd       = {8'h00, addr};         // flash byte address
        prom_blk_start = 1'b1;
    endtask

    task automatic blk_quad(input logic [BLK_ADDR_W-1:0] addr, input logic [QUAD_W-1:0] data);
        @(posedge clk);
        #1;
        clear_host();
        prom_cmd      = data;
        prom_blk_addr = addr;
        prom_blk_wen  = 1'b1;
    endtask

    task automatic blk_close();
        @(posedge clk);
        #1;
        clear_host();
        prom_blk_end = 1'b1;
    endtask

    task automatic wait_idle(input string what);
        int n;
        n = 0;
        @(posedge clk);
        #1;
        clear_host();                           // last strobe taken at this edge
        while (prom_status.busy && n < IDLE_LIMIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (prom_status.busy) begin
            $display("timeout: DUT still busy after %0d cycles in %s", n, what);
            test_errors++;
        end
    endtask

    task automatic check_equal(input string name, input logic [QUAD_W-1:0] expected,
                               input logic [QUAD_W-1:0] actual);
        assert (actual === expected) else begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            test_errors++;
        end
    endtask

    // busy must stay low while nothing was queued
    task automatic watch_quiet(input string name);
        int k;
        for (k = 0; k < 4; k++) begin
            @(posedge clk);
            #1;
            clear_host();
            check_equal(name, 32'd0, {31'd0, prom_status.busy});
        end
    endtask

    task automatic report_test(input string name);
        if (test_errors == 0) begin
            pass_count++;
            $display("test %s: ok", name);
        end else begin
            fail_count++;
            $display("test %s: %0d check(s) failed", name, test_errors);
        end
        test_errors = 0;
    endtask

    initial begin
        int i;
        seed          = 10601;
        test_errors   = 0;
        pass_count    = 0;
        fail_count    = 0;
        clk           = 1'b0;
        reset         = 1'b0;                   // active low
        prom_cmd      = '0;
        prom_blk_addr = '0;
        clear_host();
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b1;

        check_equal("reset cs", 32'd1, {31'd0, prom_status.cs});
        check_equal("reset sclk", 32'd0, {31'd0, prom_status.sclk});
        check_equal("reset busy", 32'd0, {31'd0, prom_status.busy});
        check_equal("reset overflow", 32'd0, {31'd0, prom_status.overflow});
        // only cs high, pins quiet, engine idle
        check_equal("reset status word",
                    {22'd0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, ST_IDLE},
                    prom_status);
        check_equal("reset result", 32'd0, prom_result);
        report_test("reset_state");

        reg_write({OP_RDID, 24'h0});
        wait_idle("read id");
        check_equal("read id", 32'h0020_2015, prom_result);
        report_test("read_id");

        reg_write({OP_WREN, 24'h0});
        wait_idle("wren");
        reg_write({OP_RDSR, 24'h0});
        wait_idle("rdsr");
        check_equal("wel set", 32'h0000_0002, prom_result);
        reg_write({OP_WRDI, 24'h0});
        wait_idle("wrdi");
        reg_write({OP_RDSR, 24'h0});
        wait_idle("rdsr");
        check_equal("wel clear", 32'h0000_0000, prom_result);
        reg_write({OP_DP, 24'h0});
        wait_idle("deep power down");
        reg_write({OP_RES, 24'h0});
        wait_idle("release");
        check_equal("release sig", 32'h0000_0014, prom_result);
        report_test("status_reg");

        for (i = 0; i < 8; i++)
            page[i] = $random(seed);
        reg_write({OP_WREN, 24'h0});            // program needs wel
        wait_idle("wren");
        blk_open(24'h000000);
        for (i = 0; i < 8; i++)
            blk_quad(6'(i), page[i]);
        blk_close();
        wait_idle("block write");
        check_equal("block count", 32'd8, prom_result);
        check_equal("block no overflow", 32'd0, {31'd0, prom_status.overflow});
        check_equal("block cs high", 32'd1, {31'd0, prom_status.cs});
        reg_write({OP_RDSR, 24'h0});
        wait_idle("rdsr");
        check_equal("wel after program", 32'd0, prom_result);
        reg_write({OP_READ, 24'h000000});
        wait_idle("read 0");
        check_equal("read addr 0", page[0], prom_result);
        reg_write({OP_READ, 24'h000004});
        wait_idle("read 4");
        check_equal("read addr 4", page[1], prom_result);
        reg_write({OP_FREAD, 24'h000000});
        wait_idle("fast read 0");
        check_equal("fast read addr 0", page[0], prom_result);
        reg_write({OP_FREAD, 24'h000004});
        wait_idle("fast read 4");
        check_equal("fast read addr 4", page[1], prom_result);
        report_test("block_write");

        abort_word = {8'h01, 7'h00, 9'd2, 2'b00, 6'd3};  // expected count 2 and address 3
        blk_open(24'h000040);
        blk_quad(6'd0, $random(seed));
        blk_quad(6'd1, $random(seed));
        blk_quad(6'd3, $random(seed));          // quadlet 2 skipped
        wait_idle("aborted block");
        check_equal("abort word", abort_word, prom_result);
        check_equal("abort blk_wrt", 32'd0, {31'd0, prom_status.blk_wrt});
        check_equal("abort cs high", 32'd1, {31'd0, prom_status.cs});
        report_test("block_abort");

        reg_write({OP_NOP, 24'h0});
        watch_quiet("nop busy");
        check_equal("nop result", abort_word, prom_result);
        reg_write(32'h5A00_0000);               // not in the command table
        watch_quiet("unknown busy");
        check_equal("unknown result", abort_word, prom_result);
        report_test("idle_status");

        check_equal("overflow before", 32'd0, {31'd0, prom_status.overflow});
        blk_open(24'h000080);
        for (i = 0; i < 20; i++)
            blk_quad(6'(i), $random(seed));     // faster than the spi side
        wait_idle("overflow drain");
        check_equal("overflow set", 32'd1, {31'd0, prom_status.overflow});
        blk_close();
        wait_idle("overflow close");
        check_equal("overflow cs high", 32'd1, {31'd0, prom_status.cs});
        check_equal("overflow sticky", 32'd1, {31'd0, prom_status.overflow});
        report_test("overflow");

        $display("tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
common/prom_pkg.sv
rtl/op_fifo.sv
prom_ctrl/prom_cmd_decode.sv
prom_ctrl/prom_spi_engine.sv
rtl/prom_if_top.sv
bench/m25p16_model.sv
bench/tb_prom.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the prom testbench with verilator and runs it

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_prom -f tb.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_prom > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -qF "*** TEST PASSED ***" "$log"; then
    echo "result: pass"
    exit 0
fi
echo "result: fail"
exit 1
